//--- include/pkt_settings.svh
`ifndef PKT_SETTINGS_SVH
`define PKT_SETTINGS_SVH

// Payload width of one beat.
`define PKT_DATA_W 8

// Default FIFO depth is 2**PKT_FIFO_ADDR_W entries.
`define PKT_FIFO_ADDR_W 4

// Longest legal frame in beats.
`define PKT_MAX_BEATS 12
`define PKT_CNT_W 5

`endif

//--- hw/pkt_pkg.sv
`include "pkt_settings.svh"

package pkt_pkg;

  // Payload byte of one beat.
  typedef logic [`PKT_DATA_W-1:0] data_t;

  // Beats seen so far in the current frame.
  typedef logic [`PKT_CNT_W-1:0] beat_cnt_t;

  // One stream beat. bad is the tuser marker of a bad frame.
  typedef struct packed {
    data_t data;
    logic  last;
    logic  bad;
  } axis_beat_t;

  // Ingress policer FSM.
  typedef enum logic [1:0] {
    POL_IDLE,
    POL_FRAME,
    POL_OVERSIZE
  } policer_state_t;

endpackage

//--- hw/frame_len_counter.sv
`timescale 1ns/1ps
`include "pkt_settings.svh"

module frame_len_counter (
  input  logic              clk,
  input  logic              rst,
  input  logic              beat_fire,
  input  logic              beat_last,
  output pkt_pkg::beat_cnt_t beat_count,
  output logic              over_limit
);

  localparam pkt_pkg::beat_cnt_t MAX_BEATS = pkt_pkg::beat_cnt_t'(`PKT_MAX_BEATS);
  localparam pkt_pkg::beat_cnt_t CNT_SAT   = '1;

  pkt_pkg::beat_cnt_t count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (beat_fire) begin
      if (beat_last) begin
        count_q <= '0;
      end else if (count_q != CNT_SAT) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign beat_count = count_q;

  // The limit is reached, so one more beat makes the frame oversize.
  assign over_limit = (count_q >= MAX_BEATS);

  a_no_wrap: assert property (
    @(posedge clk) disable iff (rst)
    (beat_fire && !beat_last) |=> (count_q != '0) && (count_q >= $past(count_q))
  ) else $error("frame_len_counter: beat count wrapped");

endmodule

//--- hw/ingress_policer.sv
`timescale 1ns/1ps
`include "pkt_settings.svh"

module ingress_policer (
  input  logic                clk,
  input  logic                rst,
  input  pkt_pkg::axis_beat_t in_beat,
  input  logic                in_valid,
  output logic                in_ready,
  output pkt_pkg::axis_beat_t pol_beat,
  output logic                pol_valid,
  input  logic                pol_ready,
  output logic                beat_fire,
  output logic                beat_last,
  input  logic                over_limit
);

  pkt_pkg::policer_state_t state_q;
  pkt_pkg::policer_state_t state_d;
  logic                    force_bad;

  // Straight path to the FIFO, zero latency.
  assign in_ready  = pol_ready;
  assign pol_valid = in_valid;
  assign beat_fire = in_valid && pol_ready;
  assign beat_last = in_beat.last;

  assign force_bad = (state_q == pkt_pkg::POL_OVERSIZE) || over_limit;

  always_comb begin
    pol_beat = in_beat;
    if (force_bad && in_beat.last) begin
      pol_beat.bad = 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    if (beat_fire) begin
      if (in_beat.last) begin
        state_d = pkt_pkg::POL_IDLE;
      end else if (over_limit) begin
        state_d = pkt_pkg::POL_OVERSIZE;
      end else if (state_q == pkt_pkg::POL_IDLE) begin
        state_d = pkt_pkg::POL_FRAME;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= pkt_pkg::POL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Once a frame runs past the limit, its last beat must leave marked bad.
  a_oversize_bad: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == pkt_pkg::POL_OVERSIZE && beat_fire && pol_beat.last) |-> pol_beat.bad
  ) else $error("ingress_policer: oversize frame left without bad marker");

  // The length counter stays past the limit for the rest of an oversize frame.
  a_oversize_limit: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == pkt_pkg::POL_OVERSIZE) |-> over_limit
  ) else $error("ingress_policer: oversize state while counter is under the limit");

endmodule

//--- hw/frame_fifo.sv
`timescale 1ns/1ps
`include "pkt_settings.svh"

module frame_fifo #(
  parameter int ADDR_W = `PKT_FIFO_ADDR_W
) (
  input  logic                clk,
  input  logic                rst,
  input  pkt_pkg::axis_beat_t s_beat,
  input  logic                s_valid,
  output logic                s_ready,
  output pkt_pkg::axis_beat_t m_beat,
  output logic                m_valid,
  input  logic                m_ready,
  output logic                status_good,
  output logic                status_bad,
  output logic                status_overflow
);

  localparam int DEPTH = 2 ** ADDR_W;

  // Pointers carry one extra bit to tell full from empty.
  logic [ADDR_W:0] wr_ptr_q;
  logic [ADDR_W:0] wr_ptr_d;
  logic [ADDR_W:0] wr_cur_q;
  logic [ADDR_W:0] wr_cur_d;
  logic [ADDR_W:0] rd_ptr_q;
  logic [ADDR_W:0] rd_ptr_d;
  logic [ADDR_W:0] fill;

  pkt_pkg::axis_beat_t mem [DEPTH];
  pkt_pkg::axis_beat_t mem_rd_q;
  pkt_pkg::axis_beat_t out_q;

  logic mem_vld_q;
  logic mem_vld_d;
  logic out_vld_q;
  logic out_vld_d;
  logic ready_q;
  logic drop_q;
  logic drop_d;
  logic good_q;
  logic good_d;
  logic bad_q;
  logic bad_d;
  logic ovf_q;
  logic ovf_d;
  logic s_fire;
  logic write;
  logic read;
  logic store_out;
  logic full_cur;
  logic empty;

  assign full_cur = (wr_cur_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                    (wr_cur_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);
  // Only committed frames are visible to the read side.
  assign empty    = (wr_ptr_q == rd_ptr_q);
  assign fill     = wr_cur_q - rd_ptr_q;

  // Frames are dropped when full, so the input never stalls.
  assign s_ready = ready_q;
  assign s_fire  = s_valid && ready_q;

  always_comb begin
    write    = 1'b0;
    wr_ptr_d = wr_ptr_q;
    wr_cur_d = wr_cur_q;
    drop_d   = drop_q;
    good_d   = 1'b0;
    bad_d    = 1'b0;
    ovf_d    = 1'b0;
    if (s_fire) begin
      if (full_cur || drop_q) begin
        // Discard the rest of the frame.
        drop_d = 1'b1;
        if (s_beat.last) begin
          wr_cur_d = wr_ptr_q;
          drop_d   = 1'b0;
          ovf_d    = 1'b1;
        end
      end else begin
        write    = 1'b1;
        wr_cur_d = wr_cur_q + 1'b1;
        if (s_beat.last) begin
          if (s_beat.bad) begin
            wr_cur_d = wr_ptr_q;
            bad_d    = 1'b1;
          end else begin
            wr_ptr_d = wr_cur_q + 1'b1;
            good_d   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q  <= 1'b0;
      wr_ptr_q <= '0;
      wr_cur_q <= '0;
      drop_q   <= 1'b0;
      good_q   <= 1'b0;
      bad_q    <= 1'b0;
      ovf_q    <= 1'b0;
    end else begin
      ready_q  <= 1'b1;
      wr_ptr_q <= wr_ptr_d;
      wr_cur_q <= wr_cur_d;
      drop_q   <= drop_d;
      good_q   <= good_d;
      bad_q    <= bad_d;
      ovf_q    <= ovf_d;
    end
    if (write) begin
      mem[wr_cur_q[ADDR_W-1:0]] <= s_beat;
    end
  end

  // Two-stage read pipeline, memory register then output register.
  assign store_out = m_ready || !out_vld_q;

  always_comb begin
    read      = 1'b0;
    rd_ptr_d  = rd_ptr_q;
    mem_vld_d = mem_vld_q;
    out_vld_d = out_vld_q;
    if (store_out || !mem_vld_q) begin
      if (!empty) begin
        read      = 1'b1;
        mem_vld_d = 1'b1;
        rd_ptr_d  = rd_ptr_q + 1'b1;
      end else begin
        mem_vld_d = 1'b0;
      end
    end
    if (store_out) begin
      out_vld_d = mem_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q  <= '0;
      mem_vld_q <= 1'b0;
      out_vld_q <= 1'b0;
    end else begin
      rd_ptr_q  <= rd_ptr_d;
      mem_vld_q <= mem_vld_d;
      out_vld_q <= out_vld_d;
    end
    if (read) begin
      mem_rd_q <= mem[rd_ptr_q[ADDR_W-1:0]];
    end
    if (store_out) begin
      out_q <= mem_rd_q;
    end
  end

  assign m_beat          = out_q;
  assign m_valid         = out_vld_q;
  assign status_good     = good_q;
  assign status_bad      = bad_q;
  assign status_overflow = ovf_q;

  a_ready_high: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) |-> s_ready
  ) else $error("frame_fifo: s_ready dropped outside reset");

  a_fill_bound: assert property (
    @(posedge clk) disable iff (rst)
    fill <= DEPTH
  ) else $error("frame_fifo: occupancy %0d exceeds depth", fill);

endmodule

//--- hw/pkt_buffer_top.sv
`timescale 1ns/1ps
`include "pkt_settings.svh"

module pkt_buffer_top (
  input  logic                clk,
  input  logic                rst,
  input  pkt_pkg::axis_beat_t in_beat,
  input  logic                in_valid,
  output logic                in_ready,
  output pkt_pkg::axis_beat_t out_beat,
  output logic                out_valid,
  input  logic                out_ready,
  output logic                status_good,
  output logic                status_bad,
  output logic                status_overflow
);

  pkt_pkg::axis_beat_t pol_beat;
  logic                pol_valid;
  logic                pol_ready;
  logic                beat_fire;
  logic                beat_last;
  logic                over_limit;

  ingress_policer u_policer (
    .clk        (clk),
    .rst        (rst),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .pol_beat   (pol_beat),
    .pol_valid  (pol_valid),
    .pol_ready  (pol_ready),
    .beat_fire  (beat_fire),
    .beat_last  (beat_last),
    .over_limit (over_limit)
  );

  frame_len_counter u_len_cnt (
    .clk        (clk),
    .rst        (rst),
    .beat_fire  (beat_fire),
    .beat_last  (beat_last),
    .beat_count (),
    .over_limit (over_limit)
  );

  frame_fifo #(
    .ADDR_W (`PKT_FIFO_ADDR_W)
  ) u_fifo (
    .clk             (clk),
    .rst             (rst),
    .s_beat          (pol_beat),
    .s_valid         (pol_valid),
    .s_ready         (pol_ready),
    .m_beat          (out_beat),
    .m_valid         (out_valid),
    .m_ready         (out_ready),
    .status_good     (status_good),
    .status_bad      (status_bad),
    .status_overflow (status_overflow)
  );

endmodule

//--- test/tb_pkt_buffer.sv
`timescale 1ns/1ps
`include "pkt_settings.svh"

module tb_pkt_buffer;

  localparam int CLK_PERIOD = 100;
  localparam int NROWS      = 12;
  localparam int FIFO_DEPTH = 2 ** `PKT_FIFO_ADDR_W;

  // Status codes as {overflow, bad, good}.
  localparam logic [2:0] ST_GOOD = 3'b001;
  localparam logic [2:0] ST_BAD  = 3'b010;
  localparam logic [2:0] ST_OVF  = 3'b100;

  // A len of 0 picks a random length for every frame of the row.
  typedef struct packed {
    logic [3:0] test_id;
    logic [4:0] len;
    logic       bad_in;
    logic [3:0] n_frames;
    logic       rand_ready;
    logic [2:0] exp;
  } row_t;

  row_t rows [NROWS] = '{
    '{4'd1, 5'd1,  1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd1, 5'd4,  1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd1, 5'd7,  1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd1, 5'd10, 1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd1, 5'd12, 1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd2, 5'd5,  1'b1, 4'd1, 1'b0, ST_BAD},
    '{4'd2, 5'd6,  1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd3, 5'd12, 1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd3, 5'd14, 1'b0, 4'd1, 1'b0, ST_BAD},
    '{4'd3, 5'd12, 1'b0, 4'd1, 1'b0, ST_GOOD},
    '{4'd4, 5'd20, 1'b0, 4'd1, 1'b0, ST_OVF},
    '{4'd5, 5'd0,  1'b0, 4'd8, 1'b1, ST_GOOD}
  };

  logic                clk;
  logic                rst;
  pkt_pkg::axis_beat_t in_beat;
  logic                in_valid;
  logic                in_ready;
  pkt_pkg::axis_beat_t out_beat;
  logic                out_valid;
  logic                out_ready;
  logic                status_good;
  logic                status_bad;
  logic                status_overflow;

  logic [31:0]         lfsr = 32'h72ca;
  logic                rand_ready = 1'b0;
  logic                stalled = 1'b0;
  pkt_pkg::axis_beat_t held_beat;
  pkt_pkg::axis_beat_t exp_q [$];
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cnt_good = 0;
  int cnt_bad = 0;
  int cnt_ovf = 0;
  int exp_good = 0;
  int exp_bad = 0;
  int exp_ovf = 0;

  pkt_buffer_top uut (
    .clk             (clk),
    .rst             (rst),
    .in_beat         (in_beat),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .out_beat        (out_beat),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .status_good     (status_good),
    .status_bad      (status_bad),
    .status_overflow (status_overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Galois LFSR, one step per bit taken.
  function automatic logic take_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], take_bit()};
    end
    return v;
  endfunction

  // Reference model of the frame outcome.
  function automatic logic [2:0] frame_outcome(input int len, input logic bad_in);
    if (len > FIFO_DEPTH) begin
      return ST_OVF;
    end
    if (len > `PKT_MAX_BEATS || bad_in) begin
      return ST_BAD;
    end
    return ST_GOOD;
  endfunction

  // One falling edge: count pulses, check the output side, drive out_ready.
  task automatic next_cycle();
    pkt_pkg::axis_beat_t exp_beat;
    @(negedge clk);
    if (status_good) cnt_good++;
    if (status_bad) cnt_bad++;
    if (status_overflow) cnt_ovf++;
    if (stalled) begin
      check("out_valid", 32'(out_valid), 32'd1);
      check("out_beat", 32'(out_beat), 32'(held_beat));
    end
    out_ready = rand_ready ? take_bit() : 1'b1;
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output beat %h arrived while no beat was expected", out_beat);
      end else begin
        exp_beat = exp_q.pop_front();
        check("out_beat", 32'(out_beat), 32'(exp_beat));
      end
    end
    stalled   = out_valid && !out_ready;
    held_beat = out_beat;
  endtask

  task automatic send_frame(input int len, input logic bad_in, input logic [2:0] exp_st);
    pkt_pkg::axis_beat_t beat;
    logic [2:0]          outcome;
    outcome = frame_outcome(len, bad_in);
    for (int i = 0; i < len; i++) begin
      next_cycle();
      beat.data = random_bits(8);
      beat.last = (i == len - 1);
      beat.bad  = beat.last && bad_in;
      in_beat   = beat;
      in_valid  = 1'b1;
      check("in_ready", 32'(in_ready), 32'd1);
      if (outcome == ST_GOOD) begin
        exp_q.push_back(beat);
      end
    end
    next_cycle();
    in_valid = 1'b0;
    // Status is registered on the edge that took the last beat.
    check("status", 32'({status_overflow, status_bad, status_good}), 32'(exp_st));
    if (exp_st == ST_GOOD) exp_good++;
    if (exp_st == ST_BAD) exp_bad++;
    if (exp_st == ST_OVF) exp_ovf++;
    while (exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  task automatic run_row(input row_t row);
    int len;
    rand_ready = row.rand_ready;
    for (int f = 0; f < int'(row.n_frames); f++) begin
      if (row.len == 0) begin
        len = 1 + int'(random_bits(4)) % `PKT_MAX_BEATS;
      end else begin
        len = int'(row.len);
      end
      send_frame(len, row.bad_in, row.exp);
    end
    rand_ready = 1'b0;
  endtask

  task automatic report_test(input int id, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %0d: ok", id);
    end else begin
      tests_failed++;
      $display("test %0d: FAILED with %0d errors", id, errors - err_start);
    end
  endtask

  initial begin
    int err_start;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle outputs after reset.
    err_start = errors;
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      check("out_valid", 32'(out_valid), 32'd0);
      check("status", 32'({status_overflow, status_bad, status_good}), 32'd0);
    end
    while (!in_ready) begin
      next_cycle();
    end
    report_test(6, err_start);

    for (int r = 0; r < NROWS; r++) begin
      if (r == 0 || rows[r].test_id != rows[r-1].test_id) begin
        err_start = errors;
      end
      run_row(rows[r]);
      if (r == NROWS - 1 || rows[r+1].test_id != rows[r].test_id) begin
        report_test(int'(rows[r].test_id), err_start);
      end
    end

    repeat (20) next_cycle();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected output beats never arrived", exp_q.size());
    end
    check("status_good count", 32'(cnt_good), 32'(exp_good));
    check("status_bad count", 32'(cnt_bad), 32'(exp_bad));
    check("status_overflow count", 32'(cnt_ovf), 32'(exp_ovf));
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Budget of 40 cycles per table beat, random lengths counted at the maximum.
  initial begin
    int total;
    total = 0;
    for (int r = 0; r < NROWS; r++) begin
      total += int'(rows[r].n_frames) *
               ((rows[r].len == 0) ? `PKT_MAX_BEATS : int'(rows[r].len));
    end
    repeat (total * 40) @(posedge clk);
    $display("Watchdog: the run timed out after %0d cycles", total * 40);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hw/pkt_pkg.sv
hw/frame_len_counter.sv
hw/ingress_policer.sv
hw/frame_fifo.sv
hw/pkt_buffer_top.sv
test/tb_pkt_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the packet buffer testbench with Verilator and run it.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_pkt_buffer

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module "$TOP" \
  -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation binary exited with status $run_status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
